// ==== flist.f ====
source/axi_side_pkg.sv
source/cache_side_pkg.sv
+incdir+source
source/read_channel.sv
source/write_sequencer.sv
source/beat_counter.sv
source/write_line_shifter.sv
source/axi_bridge_top.sv
verification/bridge_assertions.sv
verification/tb_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_bridge
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_bridge.sv ====
`default_nettype none

`include "bridge_defs.svh"

module tb_bridge;
  import axi_side_pkg::*;
  import cache_side_pkg::*;

  logic          aclk;
  logic          rst_n;
  logic          inst_rd_req;
  cache_rd_req_t inst_rd;
  logic          inst_rd_rdy;
  cache_ret_t    inst_ret;
  logic          data_rd_req;
  cache_rd_req_t data_rd;
  logic          data_rd_rdy;
  cache_ret_t    data_ret;
  logic          data_wr_req;
  cache_wr_req_t data_wr;
  logic          data_wr_rdy;
  axi_id_t       arid;
  axi_addr_t     araddr;
  axi_len_t      arlen;
  logic [2:0]    arsize;
  logic [1:0]    arburst;
  logic [1:0]    arlock;
  logic [3:0]    arcache;
  logic [2:0]    arprot;
  logic          arvalid;
  logic          arready;
  axi_id_t       rid;
  word_t         rdata;
  logic [1:0]    rresp;
  logic          rlast;
  logic          rvalid;
  logic          rready;
  axi_id_t       awid;
  axi_addr_t     awaddr;
  axi_len_t      awlen;
  logic [2:0]    awsize;
  logic [1:0]    awburst;
  logic [1:0]    awlock;
  logic [3:0]    awcache;
  logic [2:0]    awprot;
  logic          awvalid;
  logic          awready;
  axi_id_t       wid;
  word_t         wdata;
  strb_t         wstrb;
  logic          wlast;
  logic          wvalid;
  logic          wready;
  axi_id_t       bid;
  logic [1:0]    bresp;
  logic          bvalid;
  logic          bready;

  // slave memory and the model copy
  word_t     slave_mem [256];
  word_t     model_mem [256];
  logic      r_active;
  logic [7:0] r_idx;
  axi_len_t  r_left;
  axi_id_t   r_id;
  logic      aw_active;
  logic      b_pending;
  logic [7:0] w_idx;
  int        w_cnt;
  int        w_last_cnt;
  strb_t     w_strb_and;

  word_t     inst_q [$];
  logic      inst_lq [$];
  word_t     data_q [$];
  logic      data_lq [$];
  axi_id_t   ar_id_q [$];
  axi_len_t  ar_len_q [$];
  axi_len_t  aw_len_q [$];

  int errors;
  int beats_issued;
  int cycles;
  int req_count;
  int ret_count;

  axi_bridge_top axi_bridge_top_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // watchdog grows with the work issued
  always @(posedge aclk) begin
    cycles++;
    if (cycles > 20 * beats_issued + 500) begin
      $display("timeout: no response from the DUT after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // slave outputs change on the falling edge
  always @(negedge aclk) begin
    if (!rst_n) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
    end else begin
      arready = !r_active && ($urandom % 4 != 0);
      rvalid  = r_active && ($urandom % 4 != 0);
      rid     = r_id;
      rdata   = slave_mem[r_idx];
      rlast   = (r_left == 0);
      awready = !aw_active && !b_pending && ($urandom % 3 != 0);
      wready  = aw_active && ($urandom % 4 != 0);
      bvalid  = b_pending && ($urandom % 3 != 0);
    end
  end

  always @(posedge aclk) begin
    if (!rst_n) begin
      r_active  <= 1'b0;
      aw_active <= 1'b0;
      b_pending <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        r_active <= 1'b1;
        r_idx    <= araddr[9:2];
        r_left   <= arlen;
        r_id     <= arid;
        ar_id_q.push_back(arid);
        ar_len_q.push_back(arlen);
        // word size, incrementing burst, normal unprotected access
        check_value("{arsize,arburst,arlock,arcache,arprot}",
                    32'({arsize, arburst, arlock, arcache, arprot}),
                    32'({3'd2, 2'd1, 2'd0, 4'd0, 3'd0}));
      end
      if (rvalid && rready) begin
        r_idx  <= r_idx + 8'd1;
        r_left <= r_left - 8'd1;
        if (r_left == 0) begin
          r_active <= 1'b0;
        end
      end
      if (awvalid && awready) begin
        aw_active  <= 1'b1;
        w_idx      <= awaddr[9:2];
        w_cnt      <= 0;
        w_last_cnt <= 0;
        w_strb_and <= 4'hf;
        aw_len_q.push_back(awlen);
        check_value("{awid,awsize,awburst,awlock,awcache,awprot}",
                    32'({awid, awsize, awburst, awlock, awcache, awprot}),
                    32'({`WRITE_AXI_ID, 3'd2, 2'd1, 2'd0, 4'd0, 3'd0}));
      end
      if (wvalid && wready) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            slave_mem[w_idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        w_idx      <= w_idx + 8'd1;
        w_cnt      <= w_cnt + 1;
        w_strb_and <= w_strb_and & wstrb;
        check_value("wid", 32'(wid), 32'(`WRITE_AXI_ID));
        if (wlast) begin
          w_last_cnt <= w_cnt + 1;
          aw_active  <= 1'b0;
          b_pending  <= 1'b1;
        end
      end
      if (bvalid && bready) begin
        b_pending <= 1'b0;
      end
    end
  end

  // returns are sampled where the R beat is accepted
  always @(posedge aclk) begin
    if (inst_ret.valid) begin
      inst_q.push_back(inst_ret.word);
      inst_lq.push_back(inst_ret.last);
      if (inst_ret.last) begin
        ret_count++;
      end
    end
    if (data_ret.valid) begin
      data_q.push_back(data_ret.word);
      data_lq.push_back(data_ret.last);
      if (data_ret.last) begin
        ret_count++;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input strb_t strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic collect_read(input logic use_data, input logic is_line,
                              input logic [7:0] idx);
    int n;
    word_t w;
    logic l;
    n = is_line ? `LINE_WORDS : 1;
    while ((use_data ? data_q.size() : inst_q.size()) < n) begin
      @(posedge aclk);
    end
    for (int i = 0; i < n; i++) begin
      if (use_data) begin
        w = data_q.pop_front();
        l = data_lq.pop_front();
      end else begin
        w = inst_q.pop_front();
        l = inst_lq.pop_front();
      end
      check_value("ret.word", w, model_mem[idx + 8'(i)]);
      check_value("ret.last", 32'(l), 32'(i == n - 1));
    end
    check_value("arid", 32'(ar_id_q.pop_front()),
                32'(use_data ? `DATA_AXI_ID : `INST_AXI_ID));
    check_value("arlen", 32'(ar_len_q.pop_front()), 32'(n - 1));
  endtask

  task automatic drive_read(input logic use_data, input logic is_line,
                            input logic [7:0] idx);
    cache_rd_req_t rq;
    rq.kind = is_line ? req_line : req_word;
    rq.addr = {22'd0, idx, 2'b00};
    @(negedge aclk);
    if (use_data) begin
      data_rd     = rq;
      data_rd_req = 1'b1;
      while (!data_rd_rdy) @(negedge aclk);
      @(negedge aclk);
      data_rd_req = 1'b0;
    end else begin
      inst_rd     = rq;
      inst_rd_req = 1'b1;
      while (!inst_rd_rdy) @(negedge aclk);
      @(negedge aclk);
      inst_rd_req = 1'b0;
    end
  endtask

  task automatic read_port(input logic use_data, input logic is_line,
                           input logic [7:0] idx);
    logic [7:0] a;
    a = is_line ? {idx[7:2], 2'b00} : idx;
    beats_issued += is_line ? `LINE_WORDS : 1;
    req_count++;
    drive_read(use_data, is_line, a);
    collect_read(use_data, is_line, a);
  endtask

  task automatic write_port(input logic is_line, input logic [7:0] idx,
                            input strb_t strb, input line_t line);
    logic [7:0] a;
    a = is_line ? {idx[7:2], 2'b00} : idx;
    beats_issued += is_line ? `LINE_WORDS : 1;
    @(negedge aclk);
    data_wr.kind = is_line ? req_line : req_word;
    data_wr.addr = {22'd0, a, 2'b00};
    data_wr.strb = strb;
    data_wr.line = line;
    data_wr_req  = 1'b1;
    while (!data_wr_rdy) @(negedge aclk);
    @(negedge aclk);
    data_wr_req = 1'b0;
    if (is_line) begin
      for (int i = 0; i < `LINE_WORDS; i++) begin
        model_mem[a + 8'(i)] = line[32*i +: 32];
      end
    end else begin
      model_mem[a] = merge_bytes(model_mem[a], line[31:0], strb);
    end
    // wr_rdy comes back after the B handshake
    while (!data_wr_rdy) @(negedge aclk);
    check_value("awlen", 32'(aw_len_q.pop_front()), 32'(is_line ? `LINE_WORDS - 1 : 0));
  endtask

  function automatic line_t random_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic report_test(input int num, input string name, input int err_before);
    $display("test %0d %s: %0d errors", num, name, errors - err_before);
  endtask

  initial begin
    int e0;
    logic [7:0] idx;
    void'($urandom(75));
    rst_n = 1'b0;
    inst_rd_req = 1'b0;
    data_rd_req = 1'b0;
    data_wr_req = 1'b0;
    inst_rd = '0;
    data_rd = '0;
    data_wr = '0;
    arready = 1'b0;
    rid = '0;
    rdata = '0;
    rresp = '0;
    rlast = 1'b0;
    rvalid = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    bid = '0;
    bresp = '0;
    bvalid = 1'b0;
    r_idx = '0;
    r_left = '0;
    r_id = '0;
    w_idx = '0;
    w_cnt = 0;
    w_last_cnt = 0;
    w_strb_and = '0;
    for (int i = 0; i < 256; i++) begin
      slave_mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
      model_mem[i] = slave_mem[i];
    end
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;

    e0 = errors;
    check_value("inst_rd_rdy", 32'(inst_rd_rdy), 32'd1);
    check_value("data_rd_rdy", 32'(data_rd_rdy), 32'd1);
    check_value("data_wr_rdy", 32'(data_wr_rdy), 32'd1);
    check_value("arvalid", 32'(arvalid), 32'd0);
    check_value("awvalid", 32'(awvalid), 32'd0);
    check_value("wvalid", 32'(wvalid), 32'd0);
    check_value("bready", 32'(bready), 32'd0);
    report_test(1, "reset state", e0);

    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      read_port(1'b0, 1'($urandom), 8'($urandom));
    end
    report_test(2, "instruction reads", e0);

    // both ports in the same cycle
    e0 = errors;
    beats_issued += 2 * `LINE_WORDS;
    req_count += 2;
    @(negedge aclk);
    inst_rd     = '{kind: req_line, addr: 32'h40};
    data_rd     = '{kind: req_line, addr: 32'h80};
    inst_rd_req = 1'b1;
    data_rd_req = 1'b1;
    @(negedge aclk);
    data_rd_req = 1'b0;
    collect_read(1'b1, 1'b1, 8'h20);
    check_value("inst_q.size", 32'(inst_q.size()), 32'd0);
    while (!inst_rd_rdy) @(negedge aclk);
    @(negedge aclk);
    inst_rd_req = 1'b0;
    collect_read(1'b0, 1'b1, 8'h10);
    report_test(3, "read arbitration", e0);

    e0 = errors;
    idx = 8'($urandom);
    write_port(1'b0, idx, 4'($urandom), random_line());
    read_port(1'b1, 1'b0, idx);
    report_test(4, "word write with strobe", e0);

    e0 = errors;
    idx = 8'($urandom);
    write_port(1'b1, idx, 4'h0, random_line());
    check_value("w_beats", 32'(w_cnt), 32'd4);
    check_value("wlast_beat", 32'(w_last_cnt), 32'd4);
    check_value("wstrb", 32'(w_strb_and), 32'hf);
    read_port(1'b1, 1'b1, idx);
    report_test(5, "line write", e0);

    e0 = errors;
    req_count = 0;
    ret_count = 0;
    for (int i = 0; i < 200; i++) begin
      if ($urandom % 3 == 0) begin
        write_port(1'($urandom), 8'($urandom), 4'($urandom), random_line());
      end else begin
        read_port(1'($urandom), 1'($urandom), 8'($urandom));
      end
    end
    check_value("ret_count", 32'(ret_count), 32'(req_count));
    report_test(6, "random mix", e0);

    $display("tests 6, reads %0d, returns %0d, errors %0d", req_count, ret_count, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/bridge_assertions.sv ====
`default_nettype none

`include "bridge_defs.svh"

module bridge_assertions (
  input logic                        aclk,
  input logic                        rst_n,
  input logic                        arvalid,
  input logic                        arready,
  input axi_side_pkg::axi_id_t       arid,
  input axi_side_pkg::axi_addr_t     araddr,
  input axi_side_pkg::axi_len_t      arlen,
  input logic                        awvalid,
  input logic                        awready,
  input axi_side_pkg::axi_addr_t     awaddr,
  input axi_side_pkg::axi_len_t      awlen,
  input logic                        wvalid,
  input logic                        wready,
  input logic                        wlast,
  input cache_side_pkg::word_t       wdata,
  input cache_side_pkg::strb_t       wstrb,
  input logic                        rready,
  input axi_side_pkg::axi_id_t       rid,
  input logic                        inst_ret_valid,
  input logic                        data_ret_valid,
  input logic                        inst_rd_rdy,
  input logic                        data_rd_rdy,
  input cache_side_pkg::write_state_t wr_state
);
  import axi_side_pkg::*;
  import cache_side_pkg::*;

  axi_len_t len_q;
  axi_len_t w_cnt;

  // beats seen since the last AW handshake
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      len_q <= '0;
      w_cnt <= '0;
    end else if (awvalid && awready) begin
      len_q <= awlen;
      w_cnt <= '0;
    end else if (wvalid && wready) begin
      w_cnt <= w_cnt + 8'd1;
    end
  end

  ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable({arid, araddr, arlen}))
    else $error("arvalid or AR payload changed before arready");

  aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable({awaddr, awlen}))
    else $error("awvalid or AW payload changed before awready");

  w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable({wdata, wstrb, wlast}))
    else $error("wvalid or W payload changed before wready");

  wlast_pos: assert property (@(posedge aclk) disable iff (!rst_n)
    wvalid |-> wlast == (w_cnt == len_q))
    else $error("wlast on a beat the burst length does not imply");

  resp_beats: assert property (@(posedge aclk) disable iff (!rst_n)
    wr_state == wr_resp |-> w_cnt == len_q + 8'd1)
    else $error("write response phase entered before every W beat was sent");

  rid_owner: assert property (@(posedge aclk) disable iff (!rst_n)
    inst_ret_valid || data_ret_valid |->
      rid == (data_ret_valid ? `DATA_AXI_ID : `INST_AXI_ID))
    else $error("R beat returned on a port whose id it does not carry");

  rdy_busy: assert property (@(posedge aclk) disable iff (!rst_n)
    rready |-> !inst_rd_rdy && !data_rd_rdy)
    else $error("read port ready while a read is outstanding");

endmodule

bind axi_bridge_top bridge_assertions bridge_assertions_inst (
  .aclk           (aclk),
  .rst_n          (rst_n),
  .arvalid        (arvalid),
  .arready        (arready),
  .arid           (arid),
  .araddr         (araddr),
  .arlen          (arlen),
  .awvalid        (awvalid),
  .awready        (awready),
  .awaddr         (awaddr),
  .awlen          (awlen),
  .wvalid         (wvalid),
  .wready         (wready),
  .wlast          (wlast),
  .wdata          (wdata),
  .wstrb          (wstrb),
  .rready         (rready),
  .rid            (rid),
  .inst_ret_valid (inst_ret.valid),
  .data_ret_valid (data_ret.valid),
  .inst_rd_rdy    (inst_rd_rdy),
  .data_rd_rdy    (data_rd_rdy),
  .wr_state       (write_sequencer_inst.state)
);

`default_nettype wire

// ==== source/axi_bridge_top.sv ====
`default_nettype none

`include "bridge_defs.svh"

module axi_bridge_top (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          inst_rd_req,
  input  cache_side_pkg::cache_rd_req_t inst_rd,
  output logic                          inst_rd_rdy,
  output cache_side_pkg::cache_ret_t    inst_ret,
  input  logic                          data_rd_req,
  input  cache_side_pkg::cache_rd_req_t data_rd,
  output logic                          data_rd_rdy,
  output cache_side_pkg::cache_ret_t    data_ret,
  input  logic                          data_wr_req,
  input  cache_side_pkg::cache_wr_req_t data_wr,
  output logic                          data_wr_rdy,
  output axi_side_pkg::axi_id_t         arid,
  output axi_side_pkg::axi_addr_t       araddr,
  output axi_side_pkg::axi_len_t        arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic [1:0]                    arlock,
  output logic [3:0]                    arcache,
  output logic [2:0]                    arprot,
  output logic                          arvalid,
  input  logic                          arready,
  input  axi_side_pkg::axi_id_t         rid,
  input  cache_side_pkg::word_t         rdata,
  input  logic [1:0]                    rresp,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready,
  output axi_side_pkg::axi_id_t         awid,
  output axi_side_pkg::axi_addr_t       awaddr,
  output axi_side_pkg::axi_len_t        awlen,
  output logic [2:0]                    awsize,
  output logic [1:0]                    awburst,
  output logic [1:0]                    awlock,
  output logic [3:0]                    awcache,
  output logic [2:0]                    awprot,
  output logic                          awvalid,
  input  logic                          awready,
  output axi_side_pkg::axi_id_t         wid,
  output cache_side_pkg::word_t         wdata,
  output cache_side_pkg::strb_t         wstrb,
  output logic                          wlast,
  output logic                          wvalid,
  input  logic                          wready,
  input  axi_side_pkg::axi_id_t         bid,
  input  logic [1:0]                    bresp,
  input  logic                          bvalid,
  output logic                          bready
);
  import axi_side_pkg::*;
  import cache_side_pkg::*;

  axi_addr_req_t ar_req;
  axi_addr_req_t aw_req;
  logic          wr_load;
  logic          wr_beat;
  logic          wr_last_beat;
  logic          wr_is_line;

  read_channel read_channel_inst (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .inst_req (inst_rd_req),
    .inst_rd  (inst_rd),
    .inst_rdy (inst_rd_rdy),
    .data_req (data_rd_req),
    .data_rd  (data_rd),
    .data_rdy (data_rd_rdy),
    .ar       (ar_req),
    .arvalid  (arvalid),
    .arready  (arready),
    .rid      (rid),
    .rdata    (rdata),
    .rlast    (rlast),
    .rvalid   (rvalid),
    .rready   (rready),
    .inst_ret (inst_ret),
    .data_ret (data_ret)
  );

  write_sequencer write_sequencer_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .wr_req    (data_wr_req),
    .wr_rdy    (data_wr_rdy),
    .wr        (data_wr),
    .aw        (aw_req),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .wlast     (wlast),
    .bvalid    (bvalid),
    .bready    (bready),
    .load      (wr_load),
    .beat      (wr_beat),
    .last_beat (wr_last_beat)
  );

  // kind is sampled by the counter on load
  assign wr_is_line = (data_wr.kind == req_line);

  beat_counter beat_counter_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .load      (wr_load),
    .is_line   (wr_is_line),
    .beat      (wr_beat),
    .last_beat (wr_last_beat)
  );

  write_line_shifter write_line_shifter_inst (
    .aclk  (aclk),
    .rst_n (rst_n),
    .load  (wr_load),
    .wr    (data_wr),
    .beat  (wr_beat),
    .wdata (wdata),
    .wstrb (wstrb)
  );

  assign arid    = ar_req.id;
  assign araddr  = ar_req.addr;
  assign arlen   = ar_req.len;
  assign arsize  = `AXI_SIZE_WORD;
  assign arburst = `AXI_BURST_INCR;
  assign arlock  = `AXI_LOCK_NORMAL;
  assign arcache = `AXI_CACHE_NONE;
  assign arprot  = `AXI_PROT_NONE;

  assign awid    = aw_req.id;
  assign awaddr  = aw_req.addr;
  assign awlen   = aw_req.len;
  assign awsize  = `AXI_SIZE_WORD;
  assign awburst = `AXI_BURST_INCR;
  assign awlock  = `AXI_LOCK_NORMAL;
  assign awcache = `AXI_CACHE_NONE;
  assign awprot  = `AXI_PROT_NONE;

  // single write id, so W carries the AW id
  assign wid = `WRITE_AXI_ID;

endmodule

`default_nettype wire

// ==== source/write_line_shifter.sv ====
`default_nettype none

module write_line_shifter (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          load,
  input  cache_side_pkg::cache_wr_req_t wr,
  input  logic                          beat,
  output cache_side_pkg::word_t         wdata,
  output cache_side_pkg::strb_t         wstrb
);
  import cache_side_pkg::*;

  line_t line_q;
  strb_t strb_q;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      strb_q <= '0;
    end else if (load) begin
      // full line writes every byte
      strb_q <= (wr.kind == req_line) ? '1 : wr.strb;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      line_q <= wr.line;
    end else if (beat) begin
      line_q <= line_q >> $bits(word_t);
    end
  end

  assign wdata = line_q[$bits(word_t)-1:0];
  assign wstrb = strb_q;

endmodule

`default_nettype wire

// ==== source/beat_counter.sv ====
`default_nettype none

`include "bridge_defs.svh"

module beat_counter (
  input  logic aclk,
  input  logic rst_n,
  input  logic load,
  input  logic is_line,
  input  logic beat,
  output logic last_beat
);

  // beats still to send
  logic [2:0] remain;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      remain <= '0;
    end else if (load) begin
      remain <= is_line ? 3'(`LINE_WORDS) : 3'd1;
    end else if (beat && (remain != '0)) begin
      remain <= remain - 3'd1;
    end
  end

  assign last_beat = (remain == 3'd1);

endmodule

`default_nettype wire

// ==== source/write_sequencer.sv ====
`default_nettype none

`include "bridge_defs.svh"

module write_sequencer (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          wr_req,
  output logic                          wr_rdy,
  input  cache_side_pkg::cache_wr_req_t wr,
  output axi_side_pkg::axi_addr_req_t   aw,
  output logic                          awvalid,
  input  logic                          awready,
  output logic                          wvalid,
  input  logic                          wready,
  output logic                          wlast,
  input  logic                          bvalid,
  output logic                          bready,
  output logic                          load,
  output logic                          beat,
  input  logic                          last_beat
);
  import axi_side_pkg::*;
  import cache_side_pkg::*;

  write_state_t  state;
  write_state_t  state_nxt;
  axi_addr_req_t aw_q;

  assign wr_rdy  = (state == wr_idle);
  assign load    = wr_req && wr_rdy;
  assign awvalid = (state == wr_addr);
  assign wvalid  = (state == wr_data);
  assign bready  = (state == wr_resp);
  assign beat    = wvalid && wready;
  assign wlast   = wvalid && last_beat;
  assign aw      = aw_q;

  always_comb begin
    state_nxt = state;
    case (state)
      wr_idle: begin
        if (load) begin
          state_nxt = wr_addr;
        end
      end
      wr_addr: begin
        if (awready) begin
          state_nxt = wr_data;
        end
      end
      wr_data: begin
        // leave after the beat flagged last
        if (beat && last_beat) begin
          state_nxt = wr_resp;
        end
      end
      wr_resp: begin
        if (bvalid) begin
          state_nxt = wr_idle;
        end
      end
      default: state_nxt = wr_idle;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= wr_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      aw_q.id   <= `WRITE_AXI_ID;
      aw_q.addr <= wr.addr;
      aw_q.len  <= (wr.kind == req_line) ? axi_len_t'(`LINE_WORDS - 1) : '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/read_channel.sv ====
`default_nettype none

`include "bridge_defs.svh"

module read_channel (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          inst_req,
  input  cache_side_pkg::cache_rd_req_t inst_rd,
  output logic                          inst_rdy,
  input  logic                          data_req,
  input  cache_side_pkg::cache_rd_req_t data_rd,
  output logic                          data_rdy,
  output axi_side_pkg::axi_addr_req_t   ar,
  output logic                          arvalid,
  input  logic                          arready,
  input  axi_side_pkg::axi_id_t         rid,
  input  cache_side_pkg::word_t         rdata,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready,
  output cache_side_pkg::cache_ret_t    inst_ret,
  output cache_side_pkg::cache_ret_t    data_ret
);
  import axi_side_pkg::*;
  import cache_side_pkg::*;

  logic          busy;
  logic          owner_data;
  logic          accept;
  logic          take;
  cache_rd_req_t sel_rd;
  axi_addr_req_t ar_q;

  assign accept = !busy && (inst_req || data_req);
  // data port wins a tie
  assign sel_rd = data_req ? data_rd : inst_rd;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      owner_data <= 1'b0;
      arvalid    <= 1'b0;
    end else if (accept) begin
      busy       <= 1'b1;
      owner_data <= data_req;
      arvalid    <= 1'b1;
    end else begin
      if (arvalid && arready) begin
        arvalid <= 1'b0;
      end
      if (take && rlast) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      ar_q.id   <= data_req ? `DATA_AXI_ID : `INST_AXI_ID;
      ar_q.addr <= sel_rd.addr;
      ar_q.len  <= (sel_rd.kind == req_line) ? axi_len_t'(`LINE_WORDS - 1) : '0;
    end
  end

  assign ar       = ar_q;
  assign inst_rdy = !busy;
  assign data_rdy = !busy;

  // R beats only once the address has gone out
  assign rready = busy && !arvalid;
  assign take   = rvalid && rready && (rid == ar_q.id);

  assign inst_ret = cache_ret_t'{valid: take && !owner_data, last: rlast, word: rdata};
  assign data_ret = cache_ret_t'{valid: take && owner_data, last: rlast, word: rdata};

endmodule

`default_nettype wire

// ==== source/cache_side_pkg.sv ====
`default_nettype none

package cache_side_pkg;

  typedef logic [31:0]  word_t;
  typedef logic [3:0]   strb_t;
  // word 0 sits in the low bits
  typedef logic [127:0] line_t;

  // same codes as the cache type field
  typedef enum logic [2:0] {
    req_word = 3'b010,
    req_line = 3'b100
  } req_kind_t;

  typedef struct packed {
    req_kind_t               kind;
    axi_side_pkg::axi_addr_t addr;
  } cache_rd_req_t;

  typedef struct packed {
    req_kind_t               kind;
    axi_side_pkg::axi_addr_t addr;
    strb_t                   strb;
    line_t                   line;
  } cache_wr_req_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    word_t word;
  } cache_ret_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_addr,
    wr_data,
    wr_resp
  } write_state_t;

endpackage

`default_nettype wire

// ==== source/axi_side_pkg.sv ====
`default_nettype none

package axi_side_pkg;

  // byte address on the AXI bus
  typedef logic [31:0] axi_addr_t;

  // transaction id
  typedef logic [3:0] axi_id_t;

  // burst length minus one
  typedef logic [7:0] axi_len_t;

  // payload of an AR or AW channel
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } axi_addr_req_t;

endpackage

`default_nettype wire

// ==== source/bridge_defs.svh ====
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// AXI ids of the two read ports and the write port
`define INST_AXI_ID      4'd0
`define DATA_AXI_ID      4'd1
`define WRITE_AXI_ID     4'd1

// words per cache line
`define LINE_WORDS       4

// fixed AXI fields
`define AXI_SIZE_WORD    3'd2
`define AXI_BURST_INCR   2'd1
`define AXI_LOCK_NORMAL  2'b00
`define AXI_CACHE_NONE   4'b0000
`define AXI_PROT_NONE    3'b000

`endif
